// File: bench/conv_engine_chk.sv
`default_nettype none
`timescale 1ns/10ps

module conv_engine_chk import fu_data_pkg::*; (
	input wire            clk,
	input wire            rst_n,
	input wire            in_ready,
	input wire            out_valid,
	input wire            out_ready,
	input wire lane_vec_t out_data,
	input wire            done
);

	int unsigned assert_errs = 0;

	// loading and emitting never overlap within a tile
	a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
		!(in_ready && out_valid)) else begin
		assert_errs++;
		$error("in_ready and out_valid high in the same cycle");
	end

	a_hold: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_data)) else begin
		assert_errs++;
		$error("output word changed or dropped while stalled");
	end

	a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		done |=> !done) else begin
		assert_errs++;
		$error("done held high for more than one cycle");
	end

	// first clock out of reset
	a_reset_quiet: assert property (@(posedge clk)
		$rose(rst_n) |-> !in_ready && !out_valid && !done) else begin
		assert_errs++;
		$error("outputs not low after reset");
	end

endmodule

bind conv_engine conv_engine_chk u_conv_engine_chk (.*);

`default_nettype wire

// File: bench/tb_conv_engine.sv
`default_nettype none
`timescale 1ns/10ps

`include "fu_config.svh"

module tb_conv_engine import fu_ctrl_pkg::*, fu_data_pkg::*; ();

	localparam int SEED = 57859;
	localparam int VEC_W = `FU_SIZE * `FU_DATA_W;
	localparam int RESET_CYCLES = 8;
	localparam int MAX_K = 8;
	localparam int NUM_TILES = 13;
	// input gaps, drain, stalled rows and idle cycles around a tile
	localparam int TILE_CYCLES = 4 * MAX_K + `FU_DRAIN_CYCLES + 8 * `FU_SIZE + 20;
	localparam int WATCHDOG_NS = 2 * 10 * (RESET_CYCLES + NUM_TILES * TILE_CYCLES);

	logic      clk;
	logic      rst_n;
	logic      start;
	fu_op_e    op;
	logic      in_valid;
	logic      in_ready;
	lane_vec_t in_ifm;
	lane_vec_t in_wgt;
	logic      in_last;
	logic      out_valid;
	logic      out_ready;
	lane_vec_t out_data;
	logic      out_last;
	logic      done;
	int        err_cnt;
	int        done_cnt;
	int        tiles_run;
	lane_vec_t ifm_q[$];
	lane_vec_t wgt_q[$];
	lane_vec_t exp_q[$];

	conv_engine u_conv_engine (.*);

	always #5 clk = ~clk;

	always @(negedge clk) begin
		if (rst_n && done) begin
			done_cnt++;
		end
	end

	task automatic expect_equal(input string what, input logic [VEC_W-1:0] got,
		input logic [VEC_W-1:0] exp);
		if (got !== exp) begin
			err_cnt++;
			$display("[FAIL] %0t ns: %s, got %h expected %h", $time, what, got, exp);
		end
	endtask

	// Q7.9 product scaled back by Q and wrapped to one lane
	function automatic lane_t q_mul(lane_t a, lane_t b);
		int p;
		p = int'(a) * int'(b);
		return lane_t'(p >>> `FU_Q);
	endfunction

	function automatic lane_t leaky_ref(lane_t x);
		int t;
		t = int'(x) * `FU_RELU_PARAM;
		return (x < 0) ? lane_t'(t >>> `FU_Q) : x;
	endfunction

	function automatic lane_vec_t random_vec();
		lane_vec_t v;
		for (int i = 0; i < `FU_SIZE; i++) begin
			v[i] = lane_t'(int'($urandom_range(4095, 0)) - 2048);
		end
		return v;
	endfunction

	function automatic void build_expected(fu_op_e tile_op);
		lane_t     tile [`FU_SIZE][`FU_SIZE];
		lane_t     cand;
		lane_vec_t word;
		exp_q.delete();
		for (int r = 0; r < `FU_SIZE; r++) begin
			for (int c = 0; c < `FU_SIZE; c++) begin
				tile[r][c] = '0;
				foreach (ifm_q[b]) begin
					tile[r][c] += q_mul(ifm_q[b][r], wgt_q[b][c]);
				end
				if (tile_op != OP_LINEAR) begin
					tile[r][c] = leaky_ref(tile[r][c]);
				end
			end
		end
		if (tile_op == OP_LEAKY_POOL) begin
			for (int p = 0; p < `FU_SIZE / 2; p++) begin
				word = '0;
				for (int j = 0; j < `FU_SIZE / 2; j++) begin
					word[j] = tile[2*p][2*j];
					for (int w = 1; w < 4; w++) begin
						cand = tile[2*p+w/2][2*j+w%2];
						if (cand > word[j]) begin
							word[j] = cand;
						end
					end
				end
				exp_q.push_back(word);
			end
		end else begin
			for (int r = 0; r < `FU_SIZE; r++) begin
				for (int c = 0; c < `FU_SIZE; c++) begin
					word[c] = tile[r][c];
				end
				exp_q.push_back(word);
			end
		end
	endfunction

	task automatic send_operands(input bit gaps);
		int idle;
		for (int b = 0; b < ifm_q.size(); b++) begin
			idle = gaps ? $urandom_range(3, 0) : 0;
			in_valid = 1'b0;
			repeat (idle) @(negedge clk);
			in_valid = 1'b1;
			in_ifm = ifm_q[b];
			in_wgt = wgt_q[b];
			in_last = (b == ifm_q.size() - 1);
			while (!in_ready) @(negedge clk);
			@(negedge clk);
		end
		in_valid = 1'b0;
		in_last = 1'b0;
	endtask

	task automatic collect_rows(input bit stalls);
		int idx;
		idx = 0;
		while (idx < exp_q.size()) begin
			out_ready = stalls ? ($urandom_range(2, 0) != 0) : 1'b1;
			if (out_valid && out_ready) begin
				expect_equal($sformatf("word %0d data", idx), out_data, exp_q[idx]);
				expect_equal($sformatf("word %0d last", idx), out_last, idx == exp_q.size() - 1);
				idx++;
			end
			@(negedge clk);
		end
		out_ready = 1'b1;
	endtask

	// one full tile that starts and ends on a falling edge
	task automatic run_tile(input fu_op_e tile_op, input bit gaps, input bit stalls);
		int k;
		k = $urandom_range(MAX_K, 1);
		ifm_q.delete();
		wgt_q.delete();
		repeat (k) begin
			ifm_q.push_back(random_vec());
			wgt_q.push_back(random_vec());
		end
		build_expected(tile_op);
		expect_equal("in_ready before start", in_ready, 1'b0);
		start = 1'b1;
		op = tile_op;
		@(negedge clk);
		start = 1'b0;
		expect_equal("in_ready after start", in_ready, 1'b1);
		send_operands(gaps);
		collect_rows(stalls);
		expect_equal("done after last word", done, 1'b1);
		tiles_run++;
		@(negedge clk);
		expect_equal("done after pulse", done, 1'b0);
		expect_equal("out_valid after tile", out_valid, 1'b0);
		expect_equal("in_ready after tile", in_ready, 1'b0);
		expect_equal("done pulse count", done_cnt, tiles_run);
	endtask

	task automatic test_linear();
		run_tile(OP_LINEAR, 1'b0, 1'b0);
	endtask

	task automatic test_leaky();
		run_tile(OP_LEAKY, 1'b0, 1'b0);
	endtask

	task automatic test_pool();
		run_tile(OP_LEAKY_POOL, 1'b0, 1'b0);
	endtask

	task automatic test_stalls();
		fu_op_e tile_op;
		for (int i = 0; i < 6; i++) begin
			// odd tiles pool, even tiles stay linear
			if (i % 2 == 1) begin
				tile_op = OP_LEAKY_POOL;
			end else begin
				tile_op = OP_LINEAR;
			end
			run_tile(tile_op, 1'b1, 1'b1);
		end
	endtask

	task automatic test_back_to_back();
		for (int i = 0; i < 4; i++) begin
			repeat ($urandom_range(2, 0)) begin
				expect_equal("in_ready between tiles", in_ready, 1'b0);
				@(negedge clk);
			end
			run_tile(fu_op_e'(i % 3), 1'b0, 1'b0);
		end
	endtask

	initial begin
		void'($urandom(SEED));
		clk = 1'b0;
		rst_n = 1'b1;
		start = 1'b0;
		op = OP_LINEAR;
		in_valid = 1'b0;
		in_ifm = '0;
		in_wgt = '0;
		in_last = 1'b0;
		out_ready = 1'b0;
		err_cnt = 0;
		done_cnt = 0;
		tiles_run = 0;
		#1;
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		expect_equal("in_ready after reset", in_ready, 1'b0);
		expect_equal("out_valid after reset", out_valid, 1'b0);
		expect_equal("done after reset", done, 1'b0);
		test_linear();
		test_leaky();
		test_pool();
		test_stalls();
		test_back_to_back();
		repeat (2) @(negedge clk);
		$display("errors: %0d check, %0d assertion", err_cnt,
			u_conv_engine.u_conv_engine_chk.assert_errs);
		if (err_cnt == 0 && u_conv_engine.u_conv_engine_chk.assert_errs == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: the tiles did not finish within %0d ns", WATCHDOG_NS);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: logic/conv_engine.sv
`default_nettype none
`timescale 1ns/10ps

`include "fu_config.svh"

module conv_engine import fu_ctrl_pkg::*; import fu_data_pkg::*; (
	input  wire            clk,
	input  wire            rst_n,
	input  wire            start,
	input  wire fu_op_e    op,
	input  wire            in_valid,
	output logic           in_ready,
	input  wire lane_vec_t in_ifm,
	input  wire lane_vec_t in_wgt,
	input  wire            in_last,
	output logic           out_valid,
	input  wire            out_ready,
	output lane_vec_t      out_data,
	output logic           out_last,
	output logic           done
);

	logic                        shift_en;
	logic                        clear_acc;
	logic [$clog2(`FU_SIZE)-1:0] row_sel;
	fu_op_e                      cur_op;
	lane_vec_t                   ifm_edge;
	lane_vec_t                   wgt_edge;

	// array rows to activation, activation to pooling
	ofm_stream_if row_if ();
	ofm_stream_if act_if ();

	fu_controller u_controller (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (start),
		.op        (op),
		.in_valid  (in_valid),
		.in_last   (in_last),
		.in_ready  (in_ready),
		.shift_en  (shift_en),
		.clear_acc (clear_acc),
		.row_sel   (row_sel),
		.row_src   (row_if),
		// final word of the tile accepted downstream
		.out_fire  (out_valid && out_ready && out_last),
		.cur_op    (cur_op),
		.done      (done)
	);

	// outside S_LOAD the ladders take zeros so drain pushes only bubbles
	operand_skew u_ifm_skew (
		.clk      (clk),
		.rst_n    (rst_n),
		.shift_en (shift_en),
		.vec_in   (in_ready ? in_ifm : '0),
		.vec_out  (ifm_edge)
	);

	operand_skew u_wgt_skew (
		.clk      (clk),
		.rst_n    (rst_n),
		.shift_en (shift_en),
		.vec_in   (in_ready ? in_wgt : '0),
		.vec_out  (wgt_edge)
	);

	pe_array u_pe_array (
		.clk       (clk),
		.rst_n     (rst_n),
		.shift_en  (shift_en),
		.clear_acc (clear_acc),
		.ifm_edge  (ifm_edge),
		.wgt_edge  (wgt_edge),
		.row_sel   (row_sel),
		.row_data  (row_if.data)
	);

	leaky_relu_stage u_leaky_relu (
		.clk    (clk),
		.rst_n  (rst_n),
		.cur_op (cur_op),
		.up     (row_if),
		.dn     (act_if)
	);

	maxpool_stage u_maxpool (
		.clk       (clk),
		.rst_n     (rst_n),
		.cur_op    (cur_op),
		.up        (act_if),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_data  (out_data),
		.out_last  (out_last)
	);

endmodule

`default_nettype wire

// File: logic/fu_config.svh
`ifndef FU_CONFIG_SVH
`define FU_CONFIG_SVH

// array dimension, keep it even so pooling pairs up
`define FU_SIZE 4

// lane width and fixed point split (Q7.9)
`define FU_DATA_W 16
`define FU_Q 9

// leaky slope in Q7.9, 5/512 is close to 0.01
`define FU_RELU_PARAM 5

// wavefront needs 2N-1 shifts to clear the far corner
`define FU_DRAIN_CYCLES (2 * `FU_SIZE)

`endif

// File: logic/fu_controller.sv
`default_nettype none
`timescale 1ns/10ps

`include "fu_config.svh"

module fu_controller import fu_ctrl_pkg::*; (
	input  wire                           clk,
	input  wire                           rst_n,
	input  wire                           start,
	input  wire fu_op_e                   op,
	input  wire                           in_valid,
	input  wire                           in_last,
	output logic                          in_ready,
	output logic                          shift_en,
	output logic                          clear_acc,
	output logic [$clog2(`FU_SIZE)-1:0]   row_sel,
	ofm_stream_if.source                  row_src,
	input  wire                           out_fire,
	output fu_op_e                        cur_op,
	output logic                          done
);

	localparam int DRAIN_W = $clog2(`FU_DRAIN_CYCLES);
	localparam int ROW_W = $clog2(`FU_SIZE);
	localparam logic [DRAIN_W-1:0] DRAIN_LAST = DRAIN_W'(`FU_DRAIN_CYCLES - 1);
	localparam logic [ROW_W:0] ROWS = (ROW_W + 1)'(`FU_SIZE);

	fu_state_e          state_q;
	logic [DRAIN_W-1:0] drain_q;
	// one extra bit so the count can sit at ROWS once every row is out
	logic [ROW_W:0]     row_q;
	logic               beat_fire;
	logic               row_fire;

	assign in_ready = (state_q == S_LOAD);
	assign beat_fire = in_valid && in_ready;

	// ladders and array move on real beats, and freely while draining
	assign shift_en = beat_fire || (state_q == S_DRAIN);
	assign clear_acc = (state_q == S_IDLE) && start;

	assign row_sel = row_q[ROW_W-1:0];
	assign row_src.valid = (state_q == S_EMIT) && (row_q != ROWS);
	assign row_src.last = (row_q == ROWS - 1'b1);
	assign row_fire = row_src.valid && row_src.ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= S_IDLE;
			drain_q <= '0;
			row_q <= '0;
			cur_op <= OP_LINEAR;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state_q)
				S_IDLE: begin
					if (start) begin
						cur_op <= op;
						state_q <= S_LOAD;
					end
				end
				S_LOAD: begin
					if (beat_fire && in_last) begin
						drain_q <= '0;
						state_q <= S_DRAIN;
					end
				end
				S_DRAIN: begin
					if (drain_q == DRAIN_LAST) begin
						row_q <= '0;
						state_q <= S_EMIT;
					end else begin
						drain_q <= drain_q + 1'b1;
					end
				end
				S_EMIT: begin
					if (row_fire) begin
						row_q <= row_q + 1'b1;
					end
					// tile ends when the final word leaves the unit
					if (out_fire) begin
						done <= 1'b1;
						state_q <= S_IDLE;
					end
				end
				default: state_q <= S_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: logic/fu_ctrl_pkg.sv
`default_nettype none

package fu_ctrl_pkg;

	// per-tile output processing
	typedef enum logic [1:0] {
		OP_LINEAR,
		OP_LEAKY,
		OP_LEAKY_POOL
	} fu_op_e;

	// tile sequencing states
	typedef enum logic [2:0] {
		S_IDLE,
		S_LOAD,
		S_DRAIN,
		S_EMIT
	} fu_state_e;

endpackage

`default_nettype wire

// File: logic/fu_data_pkg.sv
`default_nettype none

`include "fu_config.svh"

package fu_data_pkg;

	// one Q7.9 lane, also the accumulator width since sums wrap
	typedef logic signed [`FU_DATA_W-1:0] lane_t;

	// a full row or column of lanes, lane 0 in the low bits
	typedef lane_t [`FU_SIZE-1:0] lane_vec_t;

	// full precision product before the Q shift
	typedef logic signed [2*`FU_DATA_W-1:0] prod_t;

endpackage

`default_nettype wire

// File: logic/leaky_relu_stage.sv
`default_nettype none
`timescale 1ns/10ps

`include "fu_config.svh"

module leaky_relu_stage import fu_ctrl_pkg::*; import fu_data_pkg::*; (
	input  wire         clk,
	input  wire         rst_n,
	input  wire fu_op_e cur_op,
	ofm_stream_if.sink  up,
	ofm_stream_if.source dn
);

	logic      full_q;
	logic      in_fire;
	logic      leaky_on;
	prod_t     scaled [`FU_SIZE];
	lane_vec_t act_vec;

	assign leaky_on = (cur_op == OP_LEAKY) || (cur_op == OP_LEAKY_POOL);

	// slot frees up in the same cycle its word is taken
	assign up.ready = !full_q || dn.ready;
	assign in_fire = up.valid && up.ready;
	assign dn.valid = full_q;

	// negative lanes get the small slope, positives pass as they are
	always_comb begin
		for (int i = 0; i < `FU_SIZE; i++) begin
			scaled[i] = $signed(up.data[i]) * `FU_RELU_PARAM;
			if (leaky_on && up.data[i][`FU_DATA_W-1]) begin
				act_vec[i] = lane_t'(scaled[i] >>> `FU_Q);
			end else begin
				act_vec[i] = up.data[i];
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			full_q <= 1'b0;
		end else begin
			full_q <= in_fire || (full_q && !dn.ready);
		end
	end

	always_ff @(posedge clk) begin
		if (in_fire) begin
			dn.data <= act_vec;
			dn.last <= up.last;
		end
	end

endmodule

`default_nettype wire

// File: logic/maxpool_stage.sv
`default_nettype none
`timescale 1ns/10ps

`include "fu_config.svh"

module maxpool_stage import fu_ctrl_pkg::*; import fu_data_pkg::*; (
	input  wire         clk,
	input  wire         rst_n,
	input  wire fu_op_e cur_op,
	ofm_stream_if.sink  up,
	output logic        out_valid,
	input  wire         out_ready,
	output lane_vec_t   out_data,
	output logic        out_last
);

	logic      pool_on;
	logic      odd_q;
	logic      hold_even;
	logic      full_q;
	logic      in_fire;
	lane_vec_t even_q;
	lane_vec_t pool_word;

	function automatic lane_t lane_max(lane_t a, lane_t b);
		return (a > b) ? a : b;
	endfunction

	assign pool_on = (cur_op == OP_LEAKY_POOL);
	// an even row only goes into the row buffer, the output slot is not needed
	assign hold_even = pool_on && !odd_q;

	assign up.ready = hold_even || !full_q || out_ready;
	assign in_fire = up.valid && up.ready;
	assign out_valid = full_q;

	// 2x2 windows at stride 2, results packed into the low half
	always_comb begin
		pool_word = '0;
		for (int j = 0; j < `FU_SIZE / 2; j++) begin
			pool_word[j] = lane_max(lane_max(even_q[2*j], even_q[2*j+1]),
				lane_max(up.data[2*j], up.data[2*j+1]));
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			full_q <= 1'b0;
			odd_q <= 1'b0;
		end else begin
			full_q <= (in_fire && !hold_even) || (full_q && !out_ready);
			if (in_fire && pool_on) begin
				odd_q <= !odd_q;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (in_fire && hold_even) begin
			even_q <= up.data;
		end
		if (in_fire && !hold_even) begin
			out_data <= pool_on ? pool_word : up.data;
			out_last <= up.last;
		end
	end

endmodule

`default_nettype wire

// File: logic/ofm_stream_if.sv
`default_nettype none
`timescale 1ns/10ps

// row stream between the emit stages, valid/ready with last
interface ofm_stream_if import fu_data_pkg::*; ();

	logic      valid;
	logic      ready;
	lane_vec_t data;
	logic      last;

	modport source (
		output valid,
		output data,
		output last,
		input  ready
	);

	modport sink (
		input  valid,
		input  data,
		input  last,
		output ready
	);

endinterface

`default_nettype wire

// File: logic/operand_skew.sv
`default_nettype none
`timescale 1ns/10ps

`include "fu_config.svh"

// lane i comes out i accepted shifts after it went in, which turns
// each beat into a diagonal wavefront at the array edge
module operand_skew import fu_data_pkg::*; (
	input  wire            clk,
	input  wire            rst_n,
	input  wire            shift_en,
	input  wire lane_vec_t vec_in,
	output lane_vec_t      vec_out
);

	for (genvar i = 0; i < `FU_SIZE; i++) begin : g_lane
		if (i == 0) begin : g_direct
			// lane 0 goes straight into the corner cell
			assign vec_out[0] = vec_in[0];
		end else begin : g_delay
			lane_t tap_q [i];

			always_ff @(posedge clk or negedge rst_n) begin
				if (!rst_n) begin
					for (int s = 0; s < i; s++) begin
						tap_q[s] <= '0;
					end
				end else if (shift_en) begin
					tap_q[0] <= vec_in[i];
					for (int s = 1; s < i; s++) begin
						tap_q[s] <= tap_q[s-1];
					end
				end
			end

			assign vec_out[i] = tap_q[i-1];
		end
	end

endmodule

`default_nettype wire

// File: logic/pe_array.sv
`default_nettype none
`timescale 1ns/10ps

`include "fu_config.svh"

// output stationary grid, ifm moves right along a row, weights move
// down a column, cell (r,c) accumulates ifm lane r times weight lane c
module pe_array import fu_data_pkg::*; (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire                          shift_en,
	input  wire                          clear_acc,
	input  wire lane_vec_t               ifm_edge,
	input  wire lane_vec_t               wgt_edge,
	input  wire [$clog2(`FU_SIZE)-1:0]   row_sel,
	output lane_vec_t                    row_data
);

	// forwarding registers between neighbours only
	lane_t a_q [`FU_SIZE][`FU_SIZE-1];
	lane_t b_q [`FU_SIZE-1][`FU_SIZE];
	lane_t acc_q [`FU_SIZE][`FU_SIZE];

	for (genvar r = 0; r < `FU_SIZE; r++) begin : g_row
		for (genvar c = 0; c < `FU_SIZE; c++) begin : g_col
			lane_t a_in;
			lane_t b_in;
			prod_t prod;

			if (c == 0) begin : g_a_edge
				assign a_in = ifm_edge[r];
			end else begin : g_a_fwd
				assign a_in = a_q[r][c-1];
			end

			if (r == 0) begin : g_b_edge
				assign b_in = wgt_edge[c];
			end else begin : g_b_fwd
				assign b_in = b_q[r-1][c];
			end

			assign prod = a_in * b_in;

			// back to Q7.9 per product, the running sum wraps at 16 bits
			always_ff @(posedge clk) begin
				if (clear_acc) begin
					acc_q[r][c] <= '0;
				end else if (shift_en) begin
					acc_q[r][c] <= acc_q[r][c] + lane_t'(prod >>> `FU_Q);
				end
			end

			if (c < `FU_SIZE - 1) begin : g_a_reg
				always_ff @(posedge clk or negedge rst_n) begin
					if (!rst_n) begin
						a_q[r][c] <= '0;
					end else if (clear_acc) begin
						a_q[r][c] <= '0;
					end else if (shift_en) begin
						a_q[r][c] <= a_in;
					end
				end
			end

			if (r < `FU_SIZE - 1) begin : g_b_reg
				always_ff @(posedge clk or negedge rst_n) begin
					if (!rst_n) begin
						b_q[r][c] <= '0;
					end else if (clear_acc) begin
						b_q[r][c] <= '0;
					end else if (shift_en) begin
						b_q[r][c] <= b_in;
					end
				end
			end
		end
	end

	always_comb begin
		for (int c = 0; c < `FU_SIZE; c++) begin
			row_data[c] = acc_q[row_sel][c];
		end
	end

endmodule

`default_nettype wire

// File: tb.f
+incdir+logic
logic/fu_ctrl_pkg.sv
logic/fu_data_pkg.sv
logic/ofm_stream_if.sv
logic/fu_controller.sv
logic/operand_skew.sv
logic/pe_array.sv
logic/leaky_relu_stage.sv
logic/maxpool_stage.sv
logic/conv_engine.sv
bench/conv_engine_chk.sv
bench/tb_conv_engine.sv
